//--- rtl/cce_settings.svh
// Width and size macros for the coherence engine
`ifndef CCE_SETTINGS_SVH
`define CCE_SETTINGS_SVH

// Request address width
`define CCE_PADDR_WIDTH 16

// Register file
`define CCE_GPR_WIDTH 16
`define CCE_NUM_GPR 8

// Microcode store
`define CCE_INST_WIDTH 32
`define CCE_INST_RAM_ELS 64

// One pending bit per way group
`define CCE_NUM_WAY_GROUPS 16

`endif

//--- rtl/cce_pkg.sv
// Opcode enum, instruction word type and vector typedefs
`default_nettype none

`include "cce_settings.svh"

package cce_pkg;

  typedef enum logic [3:0] {
    e_op_add   = 4'd0,
    e_op_sub   = 4'd1,
    e_op_and   = 4'd2,
    e_op_or    = 4'd3,
    e_op_xor   = 4'd4,
    e_op_shr   = 4'd5,
    e_op_movi  = 4'd6,
    e_op_beq   = 4'd7,
    e_op_bne   = 4'd8,
    e_op_bi    = 4'd9,
    e_op_poph  = 4'd10,
    e_op_rdp   = 4'd11,
    e_op_wdp   = 4'd12,
    e_op_send  = 4'd13,
    e_op_stall = 4'd14
  } cce_op_e;

  // op[31:28] dst[27:25] src_a[24:22] src_b[21:19] imm_sel[18] imm[15:0]
  typedef logic [`CCE_INST_WIDTH-1:0] cce_inst_t;

  typedef logic [`CCE_GPR_WIDTH-1:0] cce_gpr_t;
  typedef logic [$clog2(`CCE_NUM_GPR)-1:0] cce_gpr_id_t;
  typedef logic [`CCE_PADDR_WIDTH-1:0] cce_paddr_t;
  typedef logic [$clog2(`CCE_INST_RAM_ELS)-1:0] cce_pc_t;
  typedef logic [$clog2(`CCE_NUM_WAY_GROUPS)-1:0] cce_wg_t;

  // Immediate spans a full register
  typedef logic [`CCE_GPR_WIDTH-1:0] cce_imm_t;

endpackage

`default_nettype wire

//--- rtl/cce_pc.sv
// Program counter, microcode RAM and configuration read/write access
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_pc
  import cce_pkg::*;
  (input                 clk_i
   , input               reset_i

   , input               cfg_run_i
   , input               cfg_w_v_i
   , input               cfg_r_v_i
   , input  cce_pc_t     cfg_addr_i
   , input  cce_inst_t   cfg_data_i
   , output cce_inst_t   cfg_ucode_data_o

   , input               pc_stall_i
   , input               branch_v_i
   , input  cce_pc_t     branch_target_i

   , output cce_inst_t   inst_o
   , output logic        inst_v_o
  );

  cce_inst_t ram [`CCE_INST_RAM_ELS];
  cce_inst_t ram_data_r;

  // Address being fetched; the instruction on inst_o sits at pc_r - 1
  cce_pc_t pc_r;
  cce_pc_t ram_addr;
  logic    ram_rd_v;

  always_comb begin
    if (!cfg_run_i) begin
      ram_addr = cfg_addr_i;
    end else if (pc_stall_i) begin
      ram_addr = cce_pc_t'(pc_r - 1'b1);
    end else begin
      ram_addr = pc_r;
    end
  end

  assign ram_rd_v = cfg_run_i | cfg_r_v_i;

  always_ff @(posedge clk_i) begin
    if (cfg_w_v_i) begin
      ram[cfg_addr_i] <= cfg_data_i;
    end
    if (ram_rd_v) begin
      ram_data_r <= ram[ram_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || !cfg_run_i) begin
      pc_r     <= '0;
      inst_v_o <= 1'b0;
    end else begin
      // Wrong-path word fetched this cycle is squashed by the bubble
      inst_v_o <= !branch_v_i;
      if (branch_v_i) begin
        pc_r <= branch_target_i;
      end else if (!pc_stall_i) begin
        pc_r <= cce_pc_t'(pc_r + 1'b1);
      end
    end
  end

  assign inst_o           = ram_data_r;
  assign cfg_ucode_data_o = ram_data_r;

endmodule

`default_nettype wire

//--- rtl/cce_inst_decode.sv
// Instruction field decode with stall and branch control
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_inst_decode
  import cce_pkg::*;
  (input  cce_inst_t     inst_i
   , input               inst_v_i

   , input               lce_req_v_i
   , input               mem_cmd_ready_i
   , input               branch_res_i

   , output cce_op_e     op_o
   , output cce_gpr_id_t dst_o
   , output cce_gpr_id_t src_a_o
   , output cce_gpr_id_t src_b_o
   , output logic        imm_sel_o
   , output cce_imm_t    imm_o

   , output logic        gpr_w_v_o
   , output logic        retire_v_o
   , output logic        pc_stall_o
   , output logic        branch_v_o
   , output cce_pc_t     branch_target_o
  );

  logic stall_cond;
  logic is_branch;

  assign op_o      = cce_op_e'(inst_i[`CCE_INST_WIDTH-1 -: 4]);
  assign dst_o     = inst_i[27:25];
  assign src_a_o   = inst_i[24:22];
  assign src_b_o   = inst_i[21:19];
  assign imm_sel_o = inst_i[18];
  assign imm_o     = inst_i[15:0];

  always_comb begin
    case (op_o)
      e_op_add, e_op_sub, e_op_and, e_op_or, e_op_xor,
      e_op_shr, e_op_movi, e_op_poph, e_op_rdp: gpr_w_v_o = 1'b1;
      default: gpr_w_v_o = 1'b0;
    endcase
  end

  // Wait on the partner handshake; stall op halts the engine
  assign stall_cond = ((op_o == e_op_poph) && !lce_req_v_i)
                    || ((op_o == e_op_send) && !mem_cmd_ready_i)
                    || (op_o == e_op_stall);

  assign pc_stall_o = inst_v_i & stall_cond;
  assign retire_v_o = inst_v_i & ~stall_cond;

  assign is_branch = (op_o == e_op_beq) || (op_o == e_op_bne) || (op_o == e_op_bi);

  assign branch_v_o      = retire_v_o & is_branch & branch_res_i;
  assign branch_target_o = imm_o[$bits(cce_pc_t)-1:0];

endmodule

`default_nettype wire

//--- rtl/cce_alu.sv
// Arithmetic, logic and branch-compare unit
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_alu
  import cce_pkg::*;
  (input  cce_op_e    op_i
   , input  cce_gpr_t opd_a_i
   , input  cce_gpr_t opd_b_i
   , output cce_gpr_t res_o
   , output logic     branch_res_o
  );

  logic [$clog2(`CCE_GPR_WIDTH)-1:0] shamt;

  assign shamt = opd_b_i[$clog2(`CCE_GPR_WIDTH)-1:0];

  always_comb begin
    case (op_i)
      e_op_add:  res_o = opd_a_i + opd_b_i;
      e_op_sub:  res_o = opd_a_i - opd_b_i;
      e_op_and:  res_o = opd_a_i & opd_b_i;
      e_op_or:   res_o = opd_a_i | opd_b_i;
      e_op_xor:  res_o = opd_a_i ^ opd_b_i;
      e_op_shr:  res_o = opd_a_i >> shamt;
      e_op_movi: res_o = opd_b_i;
      default:   res_o = '0;
    endcase

    case (op_i)
      e_op_beq: branch_res_o = (opd_a_i == opd_b_i);
      e_op_bne: branch_res_o = (opd_a_i != opd_b_i);
      e_op_bi:  branch_res_o = 1'b1;
      default:  branch_res_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/cce_reg.sv
// GPR file, operand selection and writeback selection
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_reg
  import cce_pkg::*;
  (input                 clk_i
   , input               reset_i

   , input  cce_gpr_id_t src_a_i
   , input  cce_gpr_id_t src_b_i
   , input  cce_gpr_id_t dst_i
   , input               imm_sel_i
   , input  cce_imm_t    imm_i
   , input  cce_op_e     op_i

   , input               gpr_w_v_i
   , input               retire_v_i
   , input  cce_gpr_t    alu_res_i
   , input               pending_i
   , input  cce_paddr_t  lce_req_addr_i

   , output cce_gpr_t    opd_a_o
   , output cce_gpr_t    opd_b_o
  );

  cce_gpr_t gpr_r [`CCE_NUM_GPR];
  cce_gpr_t wb_data;

  // Operand b takes the immediate when selected
  assign opd_a_o = gpr_r[src_a_i];
  assign opd_b_o = imm_sel_i ? imm_i : gpr_r[src_b_i];

  always_comb begin
    case (op_i)
      e_op_rdp:  wb_data = cce_gpr_t'(pending_i);
      e_op_poph: wb_data = cce_gpr_t'(lce_req_addr_i);
      default:   wb_data = alu_res_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `CCE_NUM_GPR; i++) begin
        gpr_r[i] <= '0;
      end
    end else if (retire_v_i && gpr_w_v_i) begin
      gpr_r[dst_i] <= wb_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cce_pending.sv
// Pending-bit table indexed by way group
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_pending
  import cce_pkg::*;
  (input               clk_i
   , input             reset_i

   , input             w_v_i
   , input  cce_wg_t   w_way_group_i
   , input             pending_i

   , input  cce_wg_t   r_way_group_i
   , output logic      pending_o
  );

  logic [`CCE_NUM_WAY_GROUPS-1:0] pending_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= '0;
    end else if (w_v_i) begin
      pending_r[w_way_group_i] <= pending_i;
    end
  end

  // Read sees the old value until the write edge
  assign pending_o = pending_r[r_way_group_i];

endmodule

`default_nettype wire

//--- rtl/cce_msg.sv
// LCE request pop, memory command register and pending-bit write
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_msg
  import cce_pkg::*;
  (input                clk_i
   , input              reset_i

   , input  cce_op_e    op_i
   , input              retire_v_i
   , input  cce_gpr_t   opd_a_i
   , input  cce_gpr_t   opd_b_i
   , input  cce_imm_t   imm_i

   , output logic       lce_req_yumi_o

   , output logic       mem_cmd_v_o
   , output cce_paddr_t mem_cmd_addr_o
   , output logic       mem_cmd_flag_o

   , output logic       pending_w_v_o
   , output cce_wg_t    pending_w_way_group_o
   , output logic       pending_o
  );

  logic send_v;

  assign lce_req_yumi_o = retire_v_i & (op_i == e_op_poph);

  // Send only retires with ready high, so the command is owed next cycle
  assign send_v = retire_v_i & (op_i == e_op_send);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_cmd_v_o <= 1'b0;
    end else begin
      mem_cmd_v_o <= send_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (send_v) begin
      mem_cmd_addr_o <= opd_a_i[`CCE_PADDR_WIDTH-1:0];
      mem_cmd_flag_o <= opd_b_i[0];
    end
  end

  assign pending_w_v_o         = retire_v_i & (op_i == e_op_wdp);
  assign pending_w_way_group_o = opd_a_i[$bits(cce_wg_t)-1:0];
  assign pending_o             = imm_i[0];

endmodule

`default_nettype wire

//--- rtl/cce_top.sv
// Coherence engine top level with fetch, decode, registers, ALU, pending table and messages
`timescale 1ns/100ps
`default_nettype none

module cce_top
  import cce_pkg::*;
  (input                clk_i
   , input              reset_i

   , input              cfg_run_i
   , input              cfg_w_v_i
   , input              cfg_r_v_i
   , input  cce_pc_t    cfg_addr_i
   , input  cce_inst_t  cfg_data_i
   , output cce_inst_t  cfg_ucode_data_o

   // Inbound valid with yumi
   , input              lce_req_v_i
   , input  cce_paddr_t lce_req_addr_i
   , output logic       lce_req_yumi_o

   // Outbound ready then valid
   , input              mem_cmd_ready_i
   , output logic       mem_cmd_v_o
   , output cce_paddr_t mem_cmd_addr_o
   , output logic       mem_cmd_flag_o
  );

  cce_inst_t   inst;
  logic        inst_v;
  logic        pc_stall;
  logic        branch_v;
  cce_pc_t     branch_target;

  cce_op_e     op;
  cce_gpr_id_t dst, src_a, src_b;
  logic        imm_sel;
  cce_imm_t    imm;
  logic        gpr_w_v;
  logic        retire_v;

  cce_gpr_t    opd_a, opd_b, alu_res;
  logic        branch_res;

  logic        pending_rd;
  logic        pending_w_v;
  cce_wg_t     pending_w_way_group;
  logic        pending_wr;

  cce_pc
    i_pc
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.cfg_run_i(cfg_run_i)
      ,.cfg_w_v_i(cfg_w_v_i)
      ,.cfg_r_v_i(cfg_r_v_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_data_i(cfg_data_i)
      ,.cfg_ucode_data_o(cfg_ucode_data_o)
      ,.pc_stall_i(pc_stall)
      ,.branch_v_i(branch_v)
      ,.branch_target_i(branch_target)
      ,.inst_o(inst)
      ,.inst_v_o(inst_v)
      );

  cce_inst_decode
    i_decode
     (.inst_i(inst)
      ,.inst_v_i(inst_v)
      ,.lce_req_v_i(lce_req_v_i)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.branch_res_i(branch_res)
      ,.op_o(op)
      ,.dst_o(dst)
      ,.src_a_o(src_a)
      ,.src_b_o(src_b)
      ,.imm_sel_o(imm_sel)
      ,.imm_o(imm)
      ,.gpr_w_v_o(gpr_w_v)
      ,.retire_v_o(retire_v)
      ,.pc_stall_o(pc_stall)
      ,.branch_v_o(branch_v)
      ,.branch_target_o(branch_target)
      );

  cce_alu
    i_alu
     (.op_i(op)
      ,.opd_a_i(opd_a)
      ,.opd_b_i(opd_b)
      ,.res_o(alu_res)
      ,.branch_res_o(branch_res)
      );

  cce_reg
    i_reg
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.src_a_i(src_a)
      ,.src_b_i(src_b)
      ,.dst_i(dst)
      ,.imm_sel_i(imm_sel)
      ,.imm_i(imm)
      ,.op_i(op)
      ,.gpr_w_v_i(gpr_w_v)
      ,.retire_v_i(retire_v)
      ,.alu_res_i(alu_res)
      ,.pending_i(pending_rd)
      ,.lce_req_addr_i(lce_req_addr_i)
      ,.opd_a_o(opd_a)
      ,.opd_b_o(opd_b)
      );

  // Way group for rdp comes from the low bits of operand a
  cce_pending
    i_pending
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.w_v_i(pending_w_v)
      ,.w_way_group_i(pending_w_way_group)
      ,.pending_i(pending_wr)
      ,.r_way_group_i(opd_a[$bits(cce_wg_t)-1:0])
      ,.pending_o(pending_rd)
      );

  cce_msg
    i_msg
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.op_i(op)
      ,.retire_v_i(retire_v)
      ,.opd_a_i(opd_a)
      ,.opd_b_i(opd_b)
      ,.imm_i(imm)
      ,.lce_req_yumi_o(lce_req_yumi_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_addr_o(mem_cmd_addr_o)
      ,.mem_cmd_flag_o(mem_cmd_flag_o)
      ,.pending_w_v_o(pending_w_v)
      ,.pending_w_way_group_o(pending_w_way_group)
      ,.pending_o(pending_wr)
      );

endmodule

`default_nettype wire

//--- bench/cce_tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module cce_tb_clock
  (output logic clk_o
   , output logic reset_o
  );

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (16) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/cce_tb.sv
// Testbench for the coherence engine with microprograms, reference models and checkers
`timescale 1ns/100ps
`default_nettype none

`include "cce_settings.svh"

module cce_tb
  import cce_pkg::*;
  ();

  localparam int MAX_CYCLES = 20000;

  logic       clk_i, reset_i;
  logic       cfg_run_i, cfg_w_v_i, cfg_r_v_i;
  cce_pc_t    cfg_addr_i;
  cce_inst_t  cfg_data_i, cfg_ucode_data_o;
  logic       lce_req_v_i, lce_req_yumi_o;
  cce_paddr_t lce_req_addr_i, mem_cmd_addr_o;
  logic       mem_cmd_ready_i, mem_cmd_v_o, mem_cmd_flag_o;

  int         seed = 14541;
  int         cycle_count = 0;
  bit         throttle;
  bit         ready_seen = 1'b0;
  logic [9:0] bp_pos = '0;
  logic       ready_pat [1024];
  logic [15:0] pend_model = '0;
  cce_op_e    alu_ops [7];
  cce_imm_t   alu_imm [7];
  cce_inst_t  ucode [`CCE_INST_RAM_ELS];
  cce_paddr_t req_q [$];
  cce_paddr_t exp_addr_q [$];
  logic       exp_flag_q [$];

  cce_tb_clock i_clock (.clk_o(clk_i), .reset_o(reset_i));

  cce_top i_dut
    (.clk_i(clk_i), .reset_i(reset_i)
     , .cfg_run_i(cfg_run_i), .cfg_w_v_i(cfg_w_v_i), .cfg_r_v_i(cfg_r_v_i)
     , .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i), .cfg_ucode_data_o(cfg_ucode_data_o)
     , .lce_req_v_i(lce_req_v_i), .lce_req_addr_i(lce_req_addr_i)
     , .lce_req_yumi_o(lce_req_yumi_o)
     , .mem_cmd_ready_i(mem_cmd_ready_i), .mem_cmd_v_o(mem_cmd_v_o)
     , .mem_cmd_addr_o(mem_cmd_addr_o), .mem_cmd_flag_o(mem_cmd_flag_o));

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_inst(input string name, input cce_inst_t got, input cce_inst_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input cce_paddr_t got, input cce_paddr_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic cce_gpr_t alu_ref(input cce_op_e op, input cce_gpr_t a, input cce_gpr_t b);
    case (op)
      e_op_add:  return a + b;
      e_op_sub:  return a - b;
      e_op_and:  return a & b;
      e_op_or:   return a | b;
      e_op_xor:  return a ^ b;
      e_op_shr:  return a >> (b % 16);
      e_op_movi: return b;
      default:   return '0;
    endcase
  endfunction

  // Prior pending bit of the way group; the microprogram toggles it
  function automatic logic pend_ref(input cce_wg_t wg);
    logic prior;
    prior = pend_model[wg];
    pend_model[wg] = ~prior;
    return prior;
  endfunction

  function automatic cce_inst_t encode_inst(input cce_op_e op, input int dst, input int src_a,
                                            input int src_b, input bit imm_sel, input int imm);
    cce_inst_t w;
    w = '0;
    w[31:28] = op;
    w[27:25] = dst[2:0];
    w[24:22] = src_a[2:0];
    w[21:19] = src_b[2:0];
    w[18]    = imm_sel;
    w[15:0]  = imm[15:0];
    return w;
  endfunction

  task automatic load_and_verify();
    for (int a = 0; a < `CCE_INST_RAM_ELS; a++) begin
      cfg_w_v_i  <= 1'b1;
      cfg_addr_i <= cce_pc_t'(a);
      cfg_data_i <= ucode[a];
      @(posedge clk_i);
    end
    cfg_w_v_i <= 1'b0;
    // Back-to-back reads with each word due one cycle after its address
    for (int a = 0; a <= `CCE_INST_RAM_ELS; a++) begin
      cfg_r_v_i  <= (a < `CCE_INST_RAM_ELS);
      cfg_addr_i <= cce_pc_t'(a);
      @(posedge clk_i);
      if (a > 0) begin
        check_inst("cfg_ucode_data_o", cfg_ucode_data_o, ucode[a-1]);
      end
    end
  endtask

  task automatic run_requests(input bit gaps);
    int gap;
    for (int k = 0; k < req_q.size(); k++) begin
      gap = gaps ? ({$random(seed)} % 4) : 0;
      if (gap > 0) begin
        lce_req_v_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
      lce_req_v_i    <= 1'b1;
      lce_req_addr_i <= req_q[k];
      @(posedge clk_i);
      while (!lce_req_yumi_o) @(posedge clk_i);
    end
    lce_req_v_i <= 1'b0;
  endtask

  task automatic run_phase(input bit use_pend, input bit stress);
    foreach (req_q[k]) begin
      if (use_pend) begin
        exp_addr_q.push_back(req_q[k]);
        exp_flag_q.push_back(pend_ref(req_q[k][3:0]));
      end else begin
        for (int i = 0; i < 7; i++) begin
          exp_addr_q.push_back(alu_ref(alu_ops[i], req_q[k], alu_imm[i]));
          exp_flag_q.push_back(1'b0);
        end
      end
    end
    throttle  <= stress;
    cfg_run_i <= 1'b1;
    run_requests(stress);
    while (exp_addr_q.size() != 0) @(posedge clk_i);
    repeat (10) @(posedge clk_i);
    cfg_run_i <= 1'b0;
    throttle  <= 1'b0;
    repeat (2) @(posedge clk_i);
  endtask

  // Memory command consumer and request handshake monitor
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (lce_req_yumi_o && !lce_req_v_i) begin
        $display("yumi at %0t with no request offered", $time);
        abort_run();
      end
      if (mem_cmd_v_o) begin
        if (!ready_seen || exp_addr_q.size() == 0) begin
          $display("command at %0t without ready or beyond the expected list", $time);
          abort_run();
        end
        check_addr("mem_cmd_addr_o", mem_cmd_addr_o, exp_addr_q.pop_front());
        check_flag("mem_cmd_flag_o", mem_cmd_flag_o, exp_flag_q.pop_front());
      end
      ready_seen = mem_cmd_ready_i;
    end
  end

  initial begin
    mem_cmd_ready_i <= 1'b1;
    forever begin
      @(posedge clk_i);
      mem_cmd_ready_i <= throttle ? ready_pat[bp_pos] : 1'b1;
      bp_pos <= bp_pos + 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    cfg_run_i       <= 1'b0;
    cfg_w_v_i       <= 1'b0;
    cfg_r_v_i       <= 1'b0;
    cfg_addr_i      <= '0;
    cfg_data_i      <= '0;
    lce_req_v_i     <= 1'b0;
    lce_req_addr_i  <= '0;
    throttle        <= 1'b0;
    alu_ops = '{e_op_add, e_op_sub, e_op_and, e_op_or, e_op_xor, e_op_shr, e_op_movi};
    foreach (ready_pat[i]) ready_pat[i] = ({$random(seed)} % 4) != 0;
    foreach (alu_imm[i]) alu_imm[i] = cce_imm_t'($random(seed));
    while (reset_i !== 1'b0) @(posedge clk_i);
    check_flag("mem_cmd_v_o", mem_cmd_v_o, 1'b0);
    check_flag("lce_req_yumi_o", lce_req_yumi_o, 1'b0);

    // ALU program pops r0, applies each opcode with an immediate and sends each result
    foreach (ucode[a]) ucode[a] = cce_inst_t'($random(seed));
    ucode[0] = encode_inst(e_op_poph, 0, 0, 0, 0, 0);
    for (int i = 0; i < 7; i++) begin
      ucode[1+2*i] = encode_inst(alu_ops[i], 1, 0, 0, 1, alu_imm[i]);
      ucode[2+2*i] = encode_inst(e_op_send, 0, 1, 0, 1, 0);
    end
    ucode[15] = encode_inst(e_op_bi, 0, 0, 0, 0, 0);
    load_and_verify();
    // Idle engine must stay quiet with no request offered
    cfg_run_i <= 1'b1;
    repeat (20) @(posedge clk_i);
    for (int k = 0; k < 12; k++) req_q.push_back(cce_paddr_t'($random(seed)));
    run_phase(1'b0, 1'b0);
    run_phase(1'b0, 1'b1);

    // Pending program keeps r3 at zero as the bne operand
    foreach (ucode[a]) ucode[a] = cce_inst_t'($random(seed));
    ucode[0] = encode_inst(e_op_poph, 0, 0, 0, 0, 0);
    ucode[1] = encode_inst(e_op_and, 1, 0, 0, 1, 15);
    ucode[2] = encode_inst(e_op_rdp, 2, 1, 0, 0, 0);
    ucode[3] = encode_inst(e_op_send, 0, 0, 2, 0, 0);
    ucode[4] = encode_inst(e_op_bne, 0, 2, 3, 0, 7);
    ucode[5] = encode_inst(e_op_wdp, 0, 1, 0, 0, 1);
    ucode[6] = encode_inst(e_op_bi, 0, 0, 0, 0, 0);
    ucode[7] = encode_inst(e_op_wdp, 0, 1, 0, 0, 0);
    ucode[8] = encode_inst(e_op_bi, 0, 0, 0, 0, 0);
    load_and_verify();
    req_q.delete();
    for (int k = 0; k < 64; k++) req_q.push_back(cce_paddr_t'($random(seed)));
    run_phase(1'b1, 1'b0);
    run_phase(1'b1, 1'b1);

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/cce_pkg.sv
rtl/cce_pc.sv
rtl/cce_inst_decode.sv
rtl/cce_alu.sv
rtl/cce_reg.sv
rtl/cce_pending.sv
rtl/cce_msg.sv
rtl/cce_top.sv
bench/cce_tb_clock.sv
bench/cce_tb.sv
